// File: amo_unit.f
+incdir+src
src/amo_pkg.sv
src/amo_if.sv
src/amo_regfile.sv
src/amo_queue.sv
src/amo_translate.sv
src/amo_mem.sv
src/amo_unit.sv
tests/amo_unit_properties.sv
tests/amo_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the amo_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module amo_unit_tb -f amo_unit.f -o amo_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/amo_unit_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: src/amo_consts.svh
`ifndef AMO_CONSTS_SVH
`define AMO_CONSTS_SVH

`define AMO_XLEN       32             // Data and address width.
`define AMO_NREG       16
`define AMO_REG_W      4              // Register index width.
`define AMO_MEM_WORDS  64
`define AMO_VA_LIMIT   256            // First faulting byte address.
`define AMO_TLB_DELAY  2
`define AMO_MEM_DELAY  2

// Exception codes.
`define AMO_EXC_NONE            2'd0
`define AMO_EXC_MISALIGN_LOAD   2'd1
`define AMO_EXC_MISALIGN_STORE  2'd2
`define AMO_EXC_PAGE_FAULT      2'd3

`endif

// File: src/amo_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "amo_consts.svh"

interface amo_reg_if;
    logic [`AMO_REG_W-1:0] rs1, rs2;
    logic [`AMO_XLEN-1:0]  rdata1, rdata2;
    modport queue (output rs1, rs2, input rdata1, rdata2);
    modport regs (input rs1, rs2, output rdata1, rdata2);
endinterface

interface amo_tlb_if;
    logic                 req, valid, fault;
    logic [`AMO_XLEN-1:0] vaddr, paddr;
    modport queue (output req, vaddr, input valid, fault, paddr);
    modport tlb (input req, vaddr, output valid, fault, paddr);
endinterface

interface amo_mem_if;
    logic                 req, ready, done;
    amo_pkg::amo_op_e     op;
    logic [`AMO_XLEN-1:0] paddr, wdata, rdata;
    modport queue (output req, op, paddr, wdata, input ready, done, rdata);
    modport mem (input req, op, paddr, wdata, output ready, done, rdata);
endinterface

`default_nettype wire

// File: src/amo_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "amo_consts.svh"

module amo_mem (
    input  logic     clk,
    input  logic     rst,
    amo_mem_if.mem   mem_io
);
    localparam int CNT_W = $clog2(`AMO_MEM_DELAY + 1);
    localparam int IDX_W = $clog2(`AMO_MEM_WORDS);

    logic [`AMO_XLEN-1:0] mem [`AMO_MEM_WORDS];
    logic                 busy;
    logic [CNT_W-1:0]     cnt;
    amo_pkg::amo_op_e     op_q;
    logic [IDX_W-1:0]     idx_q, resv_idx;
    logic [`AMO_XLEN-1:0] wdata_q, old_val, new_val;
    logic                 resv_valid, sc_ok, store_en;

    assign mem_io.ready = !busy;
    assign mem_io.done  = busy && (cnt == '0);

    assign old_val  = mem[idx_q];
    assign sc_ok    = resv_valid && (resv_idx == idx_q);
    assign store_en = mem_io.done && op_q != amo_pkg::LR && (op_q != amo_pkg::SC || sc_ok);

    // SC reports its status, everything else the old word.
    assign mem_io.rdata = (op_q == amo_pkg::SC) ? {{(`AMO_XLEN-1){1'b0}}, !sc_ok} : old_val;

    always_comb begin
        case (op_q)
            amo_pkg::SWAP, amo_pkg::SC: new_val = wdata_q;
            amo_pkg::ADD: new_val = old_val + wdata_q;
            amo_pkg::AND: new_val = old_val & wdata_q;
            amo_pkg::OR:  new_val = old_val | wdata_q;
            amo_pkg::XOR: new_val = old_val ^ wdata_q;
            amo_pkg::MAX: new_val = ($signed(old_val) > $signed(wdata_q)) ? old_val : wdata_q;
            default:      new_val = old_val;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            cnt        <= '0;
            resv_valid <= 1'b0;
        end else begin
            if (mem_io.req && !busy) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`AMO_MEM_DELAY - 1);
            end else if (busy && cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else if (busy) begin
                busy <= 1'b0;
            end
            if (mem_io.done && op_q == amo_pkg::LR) begin
                resv_valid <= 1'b1;
            end else if (mem_io.done && op_q == amo_pkg::SC) begin
                resv_valid <= 1'b0;
            end else if (store_en && resv_idx == idx_q) begin
                resv_valid <= 1'b0;               // Reserved word overwritten.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_io.req && !busy) begin
            op_q    <= mem_io.op;
            idx_q   <= mem_io.paddr[IDX_W+1:2];
            wdata_q <= mem_io.wdata;
        end
        if (mem_io.done && op_q == amo_pkg::LR) begin
            resv_idx <= idx_q;
        end
        if (store_en) begin
            mem[idx_q] <= new_val;
        end
    end

endmodule

`default_nettype wire

// File: src/amo_pkg.sv
`default_nettype none

`include "amo_consts.svh"

package amo_pkg;

    typedef enum logic [2:0] {
        LR,
        SC,
        SWAP,
        ADD,
        AND,
        OR,
        XOR,
        MAX                                // Signed maximum.
    } amo_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        CHECK,
        TLB,
        MEM,
        WB
    } amo_state_e;

    typedef enum logic [1:0] {
        NONE           = `AMO_EXC_NONE,
        MISALIGN_LOAD  = `AMO_EXC_MISALIGN_LOAD,
        MISALIGN_STORE = `AMO_EXC_MISALIGN_STORE,
        PAGE_FAULT     = `AMO_EXC_PAGE_FAULT
    } amo_exc_e;

    typedef logic [3:0] amo_tag_t;

endpackage

`default_nettype wire

// File: src/amo_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "amo_consts.svh"

module amo_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  amo_pkg::amo_op_e       in_op,
    input  logic [`AMO_REG_W-1:0]  in_rs1,
    input  logic [`AMO_REG_W-1:0]  in_rs2,
    input  logic [`AMO_REG_W-1:0]  in_rd,
    input  logic                   in_we,
    input  amo_pkg::amo_tag_t      in_tag,
    amo_reg_if.queue               reg_io,
    amo_tlb_if.queue               tlb_io,
    amo_mem_if.queue               mem_io,
    output logic                   out_valid,
    input  logic                   out_ready,
    output amo_pkg::amo_tag_t      out_tag,
    output logic [`AMO_REG_W-1:0]  out_rd,
    output logic [`AMO_XLEN-1:0]   out_result,
    output amo_pkg::amo_exc_e      out_exc,
    output logic                   wb_we,
    output logic [`AMO_REG_W-1:0]  wb_addr,
    output logic [`AMO_XLEN-1:0]   wb_wdata
);
    amo_pkg::amo_state_e   state;
    amo_pkg::amo_op_e      op_q;
    amo_pkg::amo_tag_t     tag_q;
    amo_pkg::amo_exc_e     exc_q;
    logic [`AMO_REG_W-1:0] rs1_q, rs2_q, rd_q;
    logic                  we_q;
    logic [`AMO_XLEN-1:0]  addr_data, src_data;
    logic [`AMO_XLEN-1:0]  paddr_q, result_q;
    logic                  tlb_req, mem_req;

    assign in_ready = (state == amo_pkg::IDLE);

    // Operand read.
    assign reg_io.rs1 = rs1_q;
    assign reg_io.rs2 = rs2_q;

    assign tlb_io.req   = tlb_req;
    assign tlb_io.vaddr = addr_data;

    assign mem_io.req   = mem_req;
    assign mem_io.op    = op_q;
    assign mem_io.paddr = paddr_q;
    assign mem_io.wdata = src_data;

    // Instruction and operand latches.
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            op_q  <= in_op;
            rs1_q <= in_rs1;
            rs2_q <= in_rs2;
            rd_q  <= in_rd;
            we_q  <= in_we;
            tag_q <= in_tag;
        end
        if (state == amo_pkg::LOOKUP) begin
            addr_data <= reg_io.rdata1;
            src_data  <= reg_io.rdata2;
        end
        if (state == amo_pkg::TLB && tlb_io.valid) begin
            paddr_q <= tlb_io.paddr;
        end
        if (state == amo_pkg::MEM && mem_io.done) begin
            result_q <= mem_io.rdata;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= amo_pkg::IDLE;
            exc_q   <= amo_pkg::NONE;
            tlb_req <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            case (state)
                amo_pkg::IDLE: begin
                    if (in_valid) begin
                        exc_q <= amo_pkg::NONE;
                        state <= amo_pkg::LOOKUP;
                    end
                end
                amo_pkg::LOOKUP: state <= amo_pkg::CHECK;
                amo_pkg::CHECK: begin
                    if (addr_data[1:0] != 2'b00) begin
                        exc_q <= (op_q == amo_pkg::LR) ? amo_pkg::MISALIGN_LOAD
                                                       : amo_pkg::MISALIGN_STORE;
                        state <= amo_pkg::WB;
                    end else begin
                        tlb_req <= 1'b1;          // One-cycle request pulse.
                        state   <= amo_pkg::TLB;
                    end
                end
                amo_pkg::TLB: begin
                    tlb_req <= 1'b0;
                    if (tlb_io.valid && tlb_io.fault) begin
                        exc_q <= amo_pkg::PAGE_FAULT;
                        state <= amo_pkg::WB;
                    end else if (tlb_io.valid) begin
                        mem_req <= 1'b1;
                        state   <= amo_pkg::MEM;
                    end
                end
                amo_pkg::MEM: begin
                    if (mem_req && mem_io.ready) begin
                        mem_req <= 1'b0;
                    end
                    if (mem_io.done) begin
                        state <= amo_pkg::WB;
                    end
                end
                amo_pkg::WB: begin
                    if (out_ready) begin
                        state <= amo_pkg::IDLE;
                    end
                end
                default: state <= amo_pkg::IDLE;
            endcase
        end
    end

    assign out_valid  = (state == amo_pkg::WB);
    assign out_tag    = tag_q;
    assign out_rd     = rd_q;
    assign out_exc    = exc_q;
    assign out_result = (exc_q == amo_pkg::NONE) ? result_q : '0;

    // Register write on the output handshake.
    assign wb_we    = out_valid && out_ready && we_q && rd_q != '0 && exc_q == amo_pkg::NONE;
    assign wb_addr  = rd_q;
    assign wb_wdata = result_q;

endmodule

`default_nettype wire

// File: src/amo_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "amo_consts.svh"

module amo_regfile (
    input  logic                  clk,
    input  logic                  rst,
    amo_reg_if.regs               reg_io,
    input  logic                  pre_we,
    input  logic [`AMO_REG_W-1:0] pre_addr,
    input  logic [`AMO_XLEN-1:0]  pre_wdata,
    input  logic                  wb_we,
    input  logic [`AMO_REG_W-1:0] wb_addr,
    input  logic [`AMO_XLEN-1:0]  wb_wdata
);
    logic [`AMO_XLEN-1:0] regs [`AMO_NREG];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `AMO_NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_we && wb_addr != '0) begin
                regs[wb_addr] <= wb_wdata;
            end
            if (pre_we && pre_addr != '0) begin
                regs[pre_addr] <= pre_wdata;      // Later write wins on a clash.
            end
        end
    end

    // Register 0 is hardwired to zero.
    assign reg_io.rdata1 = (reg_io.rs1 == '0) ? '0 : regs[reg_io.rs1];
    assign reg_io.rdata2 = (reg_io.rs2 == '0) ? '0 : regs[reg_io.rs2];

endmodule

`default_nettype wire

// File: src/amo_translate.sv
`timescale 1ns/10ps
`default_nettype none

`include "amo_consts.svh"

module amo_translate (
    input  logic     clk,
    input  logic     rst,
    amo_tlb_if.tlb   tlb_io
);
    localparam int CNT_W = $clog2(`AMO_TLB_DELAY + 1);

    logic                 busy;
    logic [CNT_W-1:0]     cnt;
    logic [`AMO_XLEN-1:0] vaddr_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (tlb_io.req) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(`AMO_TLB_DELAY - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;                     // Answer given this cycle.
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_io.req) begin
            vaddr_q <= tlb_io.vaddr;
        end
    end

    // Identity mapping below the limit.
    assign tlb_io.valid = busy && (cnt == '0);
    assign tlb_io.fault = (vaddr_q >= `AMO_XLEN'(`AMO_VA_LIMIT));
    assign tlb_io.paddr = vaddr_q;

endmodule

`default_nettype wire

// File: src/amo_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "amo_consts.svh"

module amo_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  amo_pkg::amo_op_e      in_op,
    input  logic [`AMO_REG_W-1:0] in_rs1,
    input  logic [`AMO_REG_W-1:0] in_rs2,
    input  logic [`AMO_REG_W-1:0] in_rd,
    input  logic                  in_we,
    input  amo_pkg::amo_tag_t     in_tag,
    output logic                  out_valid,
    input  logic                  out_ready,
    output amo_pkg::amo_tag_t     out_tag,
    output logic [`AMO_REG_W-1:0] out_rd,
    output logic [`AMO_XLEN-1:0]  out_result,
    output amo_pkg::amo_exc_e     out_exc,
    input  logic                  pre_we,
    input  logic [`AMO_REG_W-1:0] pre_addr,
    input  logic [`AMO_XLEN-1:0]  pre_wdata
);
    logic                  wb_we;
    logic [`AMO_REG_W-1:0] wb_addr;
    logic [`AMO_XLEN-1:0]  wb_wdata;

    amo_reg_if reg_if ();
    amo_tlb_if tlb_if ();
    amo_mem_if mem_if ();

    amo_regfile regfile0 (
        .clk, .rst, .reg_io(reg_if.regs),
        .pre_we, .pre_addr, .pre_wdata,
        .wb_we, .wb_addr, .wb_wdata
    );

    amo_queue queue0 (
        .clk, .rst,
        .in_valid, .in_ready, .in_op, .in_rs1, .in_rs2, .in_rd, .in_we, .in_tag,
        .reg_io(reg_if.queue), .tlb_io(tlb_if.queue), .mem_io(mem_if.queue),
        .out_valid, .out_ready, .out_tag, .out_rd, .out_result, .out_exc,
        .wb_we, .wb_addr, .wb_wdata
    );

    amo_translate translate0 (.clk, .rst, .tlb_io(tlb_if.tlb));

    amo_mem mem0 (.clk, .rst, .mem_io(mem_if.mem));

endmodule

`default_nettype wire

// File: tests/amo_unit_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "amo_consts.svh"

module amo_unit_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  in_ready,
    input logic                  out_valid,
    input logic                  out_ready,
    input amo_pkg::amo_tag_t     out_tag,
    input logic [`AMO_REG_W-1:0] out_rd,
    input logic [`AMO_XLEN-1:0]  out_result,
    input amo_pkg::amo_exc_e     out_exc
);
    int ready_fails = 0;
    int hold_fails = 0;
    int reset_fails = 0;

    // Only one operation in flight.
    a_ready_low: assert property (@(posedge clk) disable iff (rst) out_valid |-> !in_ready)
        else begin
            $error("in_ready is high while out_valid is set");
            ready_fails++;
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
            out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_tag)
                                        && $stable(out_rd) && $stable(out_exc))
        else begin
            $error("Output changed while stalled by out_ready");
            hold_fails++;
        end

    a_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid is high in the cycle after reset");
            reset_fails++;
        end

endmodule

bind amo_unit amo_unit_properties props0 (
    .clk, .rst, .in_ready, .out_valid, .out_ready,
    .out_tag, .out_rd, .out_result, .out_exc
);

`default_nettype wire

// File: tests/amo_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "amo_consts.svh"

module amo_unit_tb;
    localparam int MAX_ROWS = 32;

    logic                  clk, rst;
    logic                  in_valid, in_ready, in_we, out_valid, out_ready;
    amo_pkg::amo_op_e      in_op;
    logic [`AMO_REG_W-1:0] in_rs1, in_rs2, in_rd, out_rd;
    amo_pkg::amo_tag_t     in_tag, out_tag;
    logic [`AMO_XLEN-1:0]  out_result;
    amo_pkg::amo_exc_e     out_exc;
    logic                  pre_we;
    logic [`AMO_REG_W-1:0] pre_addr;
    logic [`AMO_XLEN-1:0]  pre_wdata;

    string                 t_name [MAX_ROWS];
    amo_pkg::amo_op_e      t_op [MAX_ROWS];
    logic [`AMO_REG_W-1:0] t_rs1 [MAX_ROWS];
    logic [`AMO_REG_W-1:0] t_rs2 [MAX_ROWS];
    logic [`AMO_REG_W-1:0] t_rd [MAX_ROWS];
    logic                  t_we [MAX_ROWS];
    int                    t_stall [MAX_ROWS];
    amo_pkg::amo_exc_e     t_exc [MAX_ROWS];
    int                    n_rows;

    logic [`AMO_XLEN-1:0]  m_regs [`AMO_NREG];       // Reference model state.
    logic [`AMO_XLEN-1:0]  m_mem [`AMO_MEM_WORDS];
    logic                  m_known [`AMO_MEM_WORDS];
    logic                  m_resv_valid;
    int                    m_resv_idx;

    logic [31:0]           lcg_state;
    int                    errors, checks;
    int                    cycles = 0;

    amo_unit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= n_rows * 40) begin
            $display("Timeout: the run did not finish within %0d cycles", n_rows * 40);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic add_row(input string name, input amo_pkg::amo_op_e op,
                           input int rs1, input int rs2, input int rd, input bit we,
                           input int stall, input amo_pkg::amo_exc_e exc);
        t_name[n_rows]  = name;
        t_op[n_rows]    = op;
        t_rs1[n_rows]   = `AMO_REG_W'(rs1);
        t_rs2[n_rows]   = `AMO_REG_W'(rs2);
        t_rd[n_rows]    = `AMO_REG_W'(rd);
        t_we[n_rows]    = we;
        t_stall[n_rows] = stall;
        t_exc[n_rows]   = exc;
        n_rows++;
    endtask

    // Registers 1 to 5 hold addresses, 6 to 13 data, 14 and 15 take results.
    task automatic build_table();
        add_row("swap_init_a", amo_pkg::SWAP, 1, 6, 0, 1, 0, amo_pkg::NONE);
        add_row("swap_init_b", amo_pkg::SWAP, 2, 7, 14, 0, 0, amo_pkg::NONE);
        add_row("swap_init_c", amo_pkg::SWAP, 3, 8, 0, 0, 0, amo_pkg::NONE);
        add_row("add", amo_pkg::ADD, 1, 9, 14, 1, 0, amo_pkg::NONE);
        add_row("and", amo_pkg::AND, 1, 10, 15, 1, 0, amo_pkg::NONE);
        add_row("or", amo_pkg::OR, 1, 11, 14, 1, 0, amo_pkg::NONE);
        add_row("xor", amo_pkg::XOR, 1, 12, 15, 1, 0, amo_pkg::NONE);
        add_row("max_neg", amo_pkg::MAX, 1, 13, 14, 1, 0, amo_pkg::NONE);
        add_row("swap_updated", amo_pkg::SWAP, 1, 14, 15, 1, 2, amo_pkg::NONE);
        add_row("swap_rd_back", amo_pkg::SWAP, 2, 15, 6, 0, 0, amo_pkg::NONE);
        add_row("lr", amo_pkg::LR, 2, 0, 14, 1, 0, amo_pkg::NONE);
        add_row("sc_ok", amo_pkg::SC, 2, 9, 15, 1, 0, amo_pkg::NONE);
        add_row("sc_no_resv", amo_pkg::SC, 2, 10, 15, 1, 0, amo_pkg::NONE);
        add_row("sc_check", amo_pkg::SWAP, 2, 14, 14, 1, 0, amo_pkg::NONE);
        add_row("lr_c", amo_pkg::LR, 3, 0, 15, 1, 0, amo_pkg::NONE);
        add_row("store_between", amo_pkg::ADD, 3, 6, 0, 1, 0, amo_pkg::NONE);
        add_row("sc_after_store", amo_pkg::SC, 3, 7, 15, 1, 0, amo_pkg::NONE);
        add_row("lr_misalign", amo_pkg::LR, 4, 0, 14, 1, 0, amo_pkg::MISALIGN_LOAD);
        add_row("add_misalign", amo_pkg::ADD, 4, 6, 15, 1, 0, amo_pkg::MISALIGN_STORE);
        add_row("swap_fault", amo_pkg::SWAP, 5, 6, 14, 1, 0, amo_pkg::PAGE_FAULT);
        add_row("stall_swap", amo_pkg::SWAP, 3, 14, 15, 1, 5, amo_pkg::NONE);
        add_row("after_stall", amo_pkg::SWAP, 3, 15, 14, 1, 0, amo_pkg::NONE);
        add_row("final_a", amo_pkg::SWAP, 1, 0, 15, 1, 0, amo_pkg::NONE);
    endtask

    task automatic write_reg(input int r, input logic [31:0] v);
        pre_we    = 1'b1;
        pre_addr  = `AMO_REG_W'(r);
        pre_wdata = v;
        m_regs[r] = v;
        @(negedge clk);
        pre_we = 1'b0;
    endtask

    task automatic preload_regs();
        int r;
        write_reg(1, 32'h0000_0010);
        write_reg(2, 32'h0000_0024);
        write_reg(3, 32'h0000_003C);
        write_reg(4, 32'h0000_0012);                    // Halfword aligned only.
        write_reg(5, 32'(`AMO_VA_LIMIT));               // First faulting byte.
        for (r = 6; r <= 10; r++) begin
            write_reg(r, next_random());
        end
        write_reg(11, next_random() | 32'h8000_0000);
        write_reg(12, next_random() | 32'h8000_0000);  // With r11, word is positive before MAX.
        write_reg(13, next_random() | 32'h8000_0000);  // Negative for MAX.
    endtask

    // Expected result, exception and model update for one row.
    task automatic model_row(input int i, output logic [31:0] res,
                             output amo_pkg::amo_exc_e exc, output logic known);
        logic [31:0] addr, src, old, nv;
        int          idx;
        addr  = m_regs[t_rs1[i]];
        src   = m_regs[t_rs2[i]];
        res   = '0;
        exc   = amo_pkg::NONE;
        known = 1'b1;
        if (addr[1:0] != 2'b00) begin
            exc = (t_op[i] == amo_pkg::LR) ? amo_pkg::MISALIGN_LOAD : amo_pkg::MISALIGN_STORE;
        end else if (addr >= 32'(`AMO_VA_LIMIT)) begin
            exc = amo_pkg::PAGE_FAULT;
        end else begin
            idx   = int'(addr[7:2]);
            old   = m_mem[idx];
            known = m_known[idx];
            res   = old;
            if (t_op[i] == amo_pkg::LR) begin
                m_resv_valid = 1'b1;
                m_resv_idx   = idx;
            end else if (t_op[i] == amo_pkg::SC) begin
                known = 1'b1;
                res   = (m_resv_valid && m_resv_idx == idx) ? 32'd0 : 32'd1;
                if (res == 32'd0) begin
                    m_mem[idx]   = src;
                    m_known[idx] = 1'b1;
                end
                m_resv_valid = 1'b0;
            end else begin
                case (t_op[i])
                    amo_pkg::ADD: nv = old + src;
                    amo_pkg::AND: nv = old & src;
                    amo_pkg::OR:  nv = old | src;
                    amo_pkg::XOR: nv = old ^ src;
                    amo_pkg::MAX: nv = ($signed(src) > $signed(old)) ? src : old;
                    default:      nv = src;
                endcase
                m_mem[idx] = nv;
                if (t_op[i] == amo_pkg::SWAP) begin
                    m_known[idx] = 1'b1;
                end
                if (m_resv_valid && m_resv_idx == idx) begin
                    m_resv_valid = 1'b0;
                end
            end
        end
        if (exc == amo_pkg::NONE && t_we[i] && t_rd[i] != '0) begin
            m_regs[t_rd[i]] = res;
        end
    endtask

    task automatic run_row(input int i);
        logic [31:0]       exp_res;
        amo_pkg::amo_exc_e exp_exc;
        logic              known;
        int                errs_before, s;
        errs_before = errors;
        model_row(i, exp_res, exp_exc, known);
        while (!in_ready) begin
            @(negedge clk);
        end
        in_valid  = 1'b1;
        in_op     = t_op[i];
        in_rs1    = t_rs1[i];
        in_rs2    = t_rs2[i];
        in_rd     = t_rd[i];
        in_we     = t_we[i];
        in_tag    = 4'(i);
        out_ready = (t_stall[i] == 0);
        @(negedge clk);
        in_valid = 1'b0;
        while (!out_valid) begin
            @(negedge clk);
        end
        if (known) begin
            check_value(t_name[i], "result", exp_res, out_result);
        end
        check_value(t_name[i], "exc", 32'(t_exc[i]), 32'(out_exc));
        check_value(t_name[i], "model exc", 32'(t_exc[i]), 32'(exp_exc));
        check_value(t_name[i], "tag", 32'(in_tag), 32'(out_tag));
        check_value(t_name[i], "rd", 32'(t_rd[i]), 32'(out_rd));
        for (s = 0; s < t_stall[i]; s++) begin
            @(negedge clk);
            check_value(t_name[i], "stalled out_valid", 32'd1, 32'(out_valid));
            check_value(t_name[i], "stalled in_ready", 32'd0, 32'(in_ready));
            if (known) begin
                check_value(t_name[i], "stalled result", exp_res, out_result);
            end
        end
        out_ready = 1'b1;
        @(negedge clk);
        check_value(t_name[i], "out_valid after handshake", 32'd0, 32'(out_valid));
        $display("%s: %s", t_name[i], (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int i;
        int assert_fails;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_op     = amo_pkg::LR;
        in_rs1    = '0;
        in_rs2    = '0;
        in_rd     = '0;
        in_we     = 1'b0;
        in_tag    = '0;
        out_ready = 1'b0;
        pre_we    = 1'b0;
        pre_addr  = '0;
        pre_wdata = '0;
        errors    = 0;
        checks    = 0;
        n_rows    = 0;
        lcg_state = 32'd25;
        for (i = 0; i < `AMO_NREG; i++) begin
            m_regs[i] = '0;
        end
        for (i = 0; i < `AMO_MEM_WORDS; i++) begin
            m_mem[i]   = '0;
            m_known[i] = 1'b0;                          // Memory has no reset.
        end
        m_resv_valid = 1'b0;
        m_resv_idx   = 0;
        build_table();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        preload_regs();
        for (i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        assert_fails = dut0.props0.ready_fails + dut0.props0.hold_fails
                       + dut0.props0.reset_fails;
        $display("Rows %0d, checks %0d, check errors %0d, assertion failures %0d",
                 n_rows, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
